//--- compile.f
src/rv_isa_pkg.sv
src/exec_pkg.sv
src/int_alu.sv
src/branch_agu.sv
src/exec_commit.sv
src/exec_stage.sv
bench/tb_exec_stage.sv

//--- Bender.yml
package:
  name: exec_stage

sources:
  - files:
      - src/rv_isa_pkg.sv
      - src/exec_pkg.sv
      - src/int_alu.sv
      - src/branch_agu.sv
      - src/exec_commit.sv
      - src/exec_stage.sv
  - target: test
    files:
      - bench/tb_exec_stage.sv

//--- bench/tb_exec_stage.sv
// testbench for the execute stage: random instruction stream, reference model, output checks
`default_nettype none

module tb_exec_stage
    import rv_isa_pkg::*;
    import exec_pkg::*;
();

    localparam int clk_period   = 40;
    localparam int drive_delay  = 1;
    localparam int reset_cycles = 5;
    localparam int num_tests    = 3000;
    localparam int timeout      = (num_tests + reset_cycles + 10) * clk_period;

    logic      clk;
    logic      reset;
    logic      i_flush;
    exec_req_t i_req;
    wb_t       o_wb;
    mem_req_t  o_mem;
    redirect_t o_redirect;
    logic      o_ecall;

    // expected outputs for the request registered at the next edge
    wb_t       exp_wb;
    mem_req_t  exp_mem;
    redirect_t exp_redirect;
    logic      exp_ecall;

    integer seed = 92;

    exec_stage DUT (
        .clk        (clk),
        .reset      (reset),
        .i_req      (i_req),
        .i_flush    (i_flush),
        .o_wb       (o_wb),
        .o_mem      (o_mem),
        .o_redirect (o_redirect),
        .o_ecall    (o_ecall)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(timeout);
        $display("timeout: the run did not get through all requests in the expected time");
        $display("test failed");
        $fatal(1, "watchdog expired");
    end

    task automatic fail_value(input string what, input logic [63:0] got, input logic [63:0] exp);
        $display("** Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
        $display("test failed");
        $fatal(1, "output mismatch");
    endtask

    task automatic check_outputs();
        assert (o_wb.en === exp_wb.en) else fail_value("wb.en", o_wb.en, exp_wb.en);
        if (exp_wb.en) begin
            assert (o_wb.rd === exp_wb.rd) else fail_value("wb.rd", o_wb.rd, exp_wb.rd);
            assert (o_wb.value === exp_wb.value)
                else fail_value("wb.value", o_wb.value, exp_wb.value);
        end
        assert (o_mem.load === exp_mem.load) else fail_value("mem.load", o_mem.load, exp_mem.load);
        assert (o_mem.store === exp_mem.store)
            else fail_value("mem.store", o_mem.store, exp_mem.store);
        if (exp_mem.load || exp_mem.store) begin
            assert (o_mem.addr === exp_mem.addr)
                else fail_value("mem.addr", o_mem.addr, exp_mem.addr);
            assert (o_mem.size === exp_mem.size)
                else fail_value("mem.size", o_mem.size, exp_mem.size);
            assert (o_mem.sign_ext === exp_mem.sign_ext)
                else fail_value("mem.sign_ext", o_mem.sign_ext, exp_mem.sign_ext);
        end
        if (exp_mem.load) begin
            assert (o_mem.rd === exp_mem.rd) else fail_value("mem.rd", o_mem.rd, exp_mem.rd);
        end
        if (exp_mem.store) begin
            assert (o_mem.wdata === exp_mem.wdata)
                else fail_value("mem.wdata", o_mem.wdata, exp_mem.wdata);
        end
        assert (o_redirect.taken === exp_redirect.taken)
            else fail_value("redirect.taken", o_redirect.taken, exp_redirect.taken);
        if (exp_redirect.taken) begin
            assert (o_redirect.target === exp_redirect.target)
                else fail_value("redirect.target", o_redirect.target, exp_redirect.target);
        end
        assert (o_ecall === exp_ecall) else fail_value("ecall", o_ecall, exp_ecall);
    endtask

    // reference model, straight from the RV64I definitions
    task automatic predict(input logic [31:0] w, input xlen_t pc, input xlen_t a,
                           input xlen_t b, input logic flush);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [6:0]  f7;
        xlen_t       imm_i;
        xlen_t       imm_s;
        xlen_t       imm_b;
        xlen_t       imm_j;
        xlen_t       imm_u;
        xlen_t       alu_b;
        xlen_t       value;
        logic [31:0] value32;
        logic        alu_hit;
        logic        link;
        opc   = w[6:0];
        f3    = w[14:12];
        f7    = w[31:25];
        imm_i = {{52{w[31]}}, w[31:20]};
        imm_s = {{52{w[31]}}, w[31:25], w[11:7]};
        imm_b = {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        imm_j = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        imm_u = {{32{w[31]}}, w[31:12], 12'h000};
        alu_b = (opc == op_imm || opc == op_imm32) ? imm_i : b;
        exp_wb       = '0;
        exp_mem      = '0;
        exp_redirect = '0;
        exp_ecall    = 1'b0;
        alu_hit      = 1'b0;
        link         = 1'b0;
        value        = '0;
        value32      = '0;
        case (opc)
            op_lui: begin
                alu_hit = 1'b1;
                value   = imm_u;
            end
            op_auipc: begin
                alu_hit = 1'b1;
                value   = pc + imm_u;
            end
            op_imm, op_reg: begin
                if (opc == op_imm) begin
                    alu_hit = (f3 == f3_sll) ? w[31:26] == 6'd0 :
                              (f3 == f3_srl_sra) ? w[31:26] inside {6'd0, 6'b010000} : 1'b1;
                end else begin
                    alu_hit = f7 == 7'd0 || (f7 == funct7_alt && f3 inside {3'd0, 3'd5});
                end
                case (f3)
                    3'd0: value = (opc == op_reg && w[30]) ? a - alu_b : a + alu_b;
                    3'd1: value = a << alu_b[5:0];
                    3'd2: value = {63'd0, $signed(a) < $signed(alu_b)};
                    3'd3: value = {63'd0, a < alu_b};
                    3'd4: value = a ^ alu_b;
                    3'd5: begin
                        if (w[30]) value = $signed(a) >>> alu_b[5:0];
                        else value = a >> alu_b[5:0];
                    end
                    3'd6: value = a | alu_b;
                    default: value = a & alu_b;
                endcase
            end
            op_imm32, op_reg32: begin
                case (f3)
                    3'd0: begin
                        alu_hit = opc == op_imm32 || f7 == 7'd0 || f7 == funct7_alt;
                        value32 = (opc == op_reg32 && w[30]) ? a[31:0] - alu_b[31:0]
                                                              : a[31:0] + alu_b[31:0];
                    end
                    3'd1: begin
                        alu_hit = f7 == 7'd0;
                        value32 = a[31:0] << alu_b[4:0];
                    end
                    3'd5: begin
                        alu_hit = f7 == 7'd0 || f7 == funct7_alt;
                        if (w[30]) value32 = $signed(a[31:0]) >>> alu_b[4:0];
                        else value32 = a[31:0] >> alu_b[4:0];
                    end
                    default: alu_hit = 1'b0;
                endcase
                value = {{32{value32[31]}}, value32};
            end
            op_jal: begin
                link                = 1'b1;
                exp_redirect.taken  = 1'b1;
                exp_redirect.target = pc + imm_j;
            end
            op_jalr: begin
                link                = f3 == 3'd0;
                exp_redirect.taken  = f3 == 3'd0;
                exp_redirect.target = (a + imm_i) & ~64'd1;
            end
            op_branch: begin
                case (f3)
                    f3_beq:  exp_redirect.taken = a == b;
                    f3_bne:  exp_redirect.taken = a != b;
                    f3_blt:  exp_redirect.taken = $signed(a) < $signed(b);
                    f3_bge:  exp_redirect.taken = $signed(a) >= $signed(b);
                    f3_bltu: exp_redirect.taken = a < b;
                    f3_bgeu: exp_redirect.taken = a >= b;
                    default: exp_redirect.taken = 1'b0;
                endcase
                exp_redirect.target = pc + imm_b;
            end
            op_load: begin
                exp_mem.load     = f3 != 3'd7;
                exp_mem.rd       = w[11:7];
                exp_mem.addr     = a + imm_i;
                exp_mem.size     = mem_size_e'(f3[1:0]);
                exp_mem.sign_ext = f3 <= 3'd2;    // lb, lh, lw
            end
            op_store: begin
                exp_mem.store = !f3[2];
                exp_mem.addr  = a + imm_s;
                exp_mem.size  = mem_size_e'(f3[1:0]);
                case (f3[1:0])
                    2'd0: exp_mem.wdata = {56'd0, b[7:0]};
                    2'd1: exp_mem.wdata = {48'd0, b[15:0]};
                    2'd2: exp_mem.wdata = {32'd0, b[31:0]};
                    default: exp_mem.wdata = b;
                endcase
            end
            op_system: exp_ecall = f3 == 3'd0 && w[31:20] == 12'd0;
            default: alu_hit = 1'b0;
        endcase
        exp_wb.en    = (alu_hit || link) && w[11:7] != 5'd0 && !flush;
        exp_wb.rd    = w[11:7];
        exp_wb.value = link ? pc + 64'd4 : value;
        if (flush) begin
            exp_mem.load       = 1'b0;
            exp_mem.store      = 1'b0;
            exp_redirect.taken = 1'b0;
            exp_ecall          = 1'b0;
        end
    endtask

    task automatic drive_request();
        logic [31:0] w;
        logic [2:0]  f3;
        int unsigned kind;
        int unsigned pick;
        xlen_t       a;
        xlen_t       b;
        xlen_t       pc;
        logic        flush;
        w     = $random(seed);
        kind  = $unsigned($random(seed)) % 13;
        pick  = $unsigned($random(seed)) % 8;
        f3    = w[14:12];
        a     = {$random(seed), $random(seed)};
        b     = (pick[1:0] == 2'd0) ? a : {$random(seed), $random(seed)};
        pc    = {$random(seed), $random(seed)} & ~64'd3;
        flush = ($unsigned($random(seed)) % 16) == 0;
        case (kind)
            0: w[6:0] = op_lui;
            1: w[6:0] = op_auipc;
            2: w[6:0] = op_jal;
            3: w = {w[31:15], 3'b000, w[11:7], op_jalr};
            4: begin
                if (f3 == 3'b010 || f3 == 3'b011) w[14] = 1'b1;    // skip reserved funct3
                w[6:0] = op_branch;
            end
            5: begin
                if (f3 == 3'b111) w[14] = 1'b0;
                w[6:0] = op_load;
            end
            6: w = {w[31:15], 1'b0, w[13:7], op_store};
            7: begin
                if (f3 == f3_sll) w[31:26] = 6'd0;
                if (f3 == f3_srl_sra) w[31:26] = {1'b0, pick[0], 4'd0};
                w[6:0] = op_imm;
            end
            8, 9: begin
                f3 = (pick % 3 == 0) ? f3_add_sub : ((pick % 3 == 1) ? f3_sll : f3_srl_sra);
                if (kind == 9 || f3 != f3_add_sub) begin
                    w[31:25] = (f3 != f3_sll && pick[0]) ? funct7_alt : 7'd0;
                end
                w[14:12] = f3;
                w[6:0]   = (kind == 8) ? op_imm32 : op_reg32;
            end
            10: begin
                w[31:25] = (f3 inside {f3_add_sub, f3_srl_sra} && pick[0]) ? funct7_alt : 7'd0;
                w[6:0]   = op_reg;
            end
            11: w = 32'h0000_0073;    // ecall
            default: begin
                case (pick[1:0])
                    2'd0: w = {7'b0000001, w[24:7], op_reg};    // M extension
                    2'd1: w = {w[31:7], 7'b0001111};            // fence
                    2'd2: w = 32'h0010_0073;                    // ebreak
                    default: w = {w[31:15], 3'b010, w[11:7], op_imm32};
                endcase
            end
        endcase
        i_req.pc      = pc;
        i_req.inst    = w;
        i_req.rs1_val = a;
        i_req.rs2_val = b;
        i_flush       = flush;
        predict(w, pc, a, b, flush);
    endtask

    initial begin
        reset        = 1'b1;
        i_flush      = 1'b0;
        i_req        = '0;
        exp_wb       = '0;
        exp_mem      = '0;
        exp_redirect = '0;
        exp_ecall    = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #(drive_delay);
        check_outputs();    // idle straight out of reset
        reset = 1'b0;
        for (int n = 0; n <= num_tests; n++) begin
            @(posedge clk);
            #(drive_delay);
            check_outputs();
            if (n < num_tests) begin
                drive_request();
            end
        end
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- src/exec_stage.sv
// execute stage top: ALU and branch/address unit in parallel, then commit register
`default_nettype none

module exec_stage
    import exec_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  exec_req_t i_req,
    input  logic      i_flush,
    output wb_t       o_wb,
    output mem_req_t  o_mem,
    output redirect_t o_redirect,
    output logic      o_ecall
);

    alu_result_t  alu_result;
    ctrl_result_t ctrl_result;

    int_alu u_int_alu (
        .i_req (i_req),
        .o_alu (alu_result)
    );

    branch_agu u_branch_agu (
        .i_req  (i_req),
        .o_ctrl (ctrl_result)
    );

    exec_commit u_exec_commit (
        .clk        (clk),
        .reset      (reset),
        .i_flush    (i_flush),
        .i_rd       (i_req.inst.r.rd),    // same field in every format that writes
        .i_alu      (alu_result),
        .i_ctrl     (ctrl_result),
        .o_wb       (o_wb),
        .o_mem      (o_mem),
        .o_redirect (o_redirect),
        .o_ecall    (o_ecall)
    );

endmodule

`default_nettype wire

//--- src/exec_commit.sv
// result merge, flush squash and output register of the execute stage
`default_nettype none

module exec_commit
    import rv_isa_pkg::*;
    import exec_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         i_flush,
    input  reg_addr_t    i_rd,
    input  alu_result_t  i_alu,
    input  ctrl_result_t i_ctrl,
    output wb_t          o_wb,
    output mem_req_t     o_mem,
    output redirect_t    o_redirect,
    output logic         o_ecall
);

    logic  wb_en;
    xlen_t wb_value;

    // the two units own disjoint opcodes, no priority needed beyond link
    assign wb_en    = (i_alu.hit || i_ctrl.link) && i_rd != '0 && !i_flush;
    assign wb_value = i_ctrl.link ? i_ctrl.link_value : i_alu.value;

    always_ff @(posedge clk) begin
        o_wb.rd           <= i_rd;
        o_wb.value        <= wb_value;
        o_mem             <= i_ctrl.mem;
        o_redirect.target <= i_ctrl.target;

        // strobes
        if (reset) begin
            o_wb.en          <= 1'b0;
            o_mem.load       <= 1'b0;
            o_mem.store      <= 1'b0;
            o_redirect.taken <= 1'b0;
            o_ecall          <= 1'b0;
        end else begin
            o_wb.en          <= wb_en;
            o_mem.load       <= i_ctrl.mem.load && !i_flush;
            o_mem.store      <= i_ctrl.mem.store && !i_flush;
            o_redirect.taken <= i_ctrl.taken && !i_flush;
            o_ecall          <= i_ctrl.ecall && !i_flush;
        end
    end

    a_wb_rd_nonzero: assert property (@(posedge clk) disable iff (reset)
        o_wb.en |-> o_wb.rd != '0)
        else $error("writeback enabled to x0");

    a_idle_after_reset: assert property (@(posedge clk)
        reset |=> !(o_wb.en || o_mem.load || o_mem.store || o_redirect.taken || o_ecall))
        else $error("output strobe active after reset");

endmodule

`default_nettype wire

//--- src/branch_agu.sv
// branch resolution, jump targets and links, load/store requests, ecall detection
`default_nettype none

module branch_agu
    import rv_isa_pkg::*;
    import exec_pkg::*;
(
    input  exec_req_t    i_req,
    output ctrl_result_t o_ctrl
);

    inst_t     inst;
    xlen_t     rs1;
    xlen_t     rs2;
    xlen_t     imm_i;
    xlen_t     imm_s;
    xlen_t     imm_b;
    xlen_t     imm_j;
    xlen_t     jalr_sum;
    xlen_t     size_mask;
    mem_size_e size;
    logic      cond;

    always_comb begin
        inst  = i_req.inst;
        rs1   = i_req.rs1_val;
        rs2   = i_req.rs2_val;
        imm_i = {{(xlen-12){inst.i.imm[11]}}, inst.i.imm};
        imm_s = {{(xlen-12){inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
        imm_b = {{(xlen-13){inst.b.imm_12}}, inst.b.imm_12, inst.b.imm_11,
                 inst.b.imm_10_5, inst.b.imm_4_1, 1'b0};
        imm_j = {{(xlen-21){inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12,
                 inst.j.imm_11, inst.j.imm_10_1, 1'b0};
        jalr_sum = rs1 + imm_i;

        case (inst.b.funct3)
            f3_beq:  cond = rs1 == rs2;
            f3_bne:  cond = rs1 != rs2;
            f3_blt:  cond = $signed(rs1) < $signed(rs2);
            f3_bge:  cond = $signed(rs1) >= $signed(rs2);
            f3_bltu: cond = rs1 < rs2;
            f3_bgeu: cond = rs1 >= rs2;
            default: cond = 1'b0;    // 010/011 reserved
        endcase

        size = mem_size_e'(inst.i.funct3[1:0]);
        case (size)
            size_byte:   size_mask = xlen_t'(8'hff);
            size_half:   size_mask = xlen_t'(16'hffff);
            size_word:   size_mask = xlen_t'(32'hffff_ffff);
            size_double: size_mask = '1;
        endcase
    end

    always_comb begin
        o_ctrl = '0;
        case (inst.i.opcode)
            op_jal: begin
                o_ctrl.link       = 1'b1;
                o_ctrl.link_value = i_req.pc + xlen_t'(4);
                o_ctrl.taken      = 1'b1;
                o_ctrl.target     = i_req.pc + imm_j;
            end
            op_jalr: begin
                if (inst.i.funct3 == 3'b000) begin
                    o_ctrl.link       = 1'b1;
                    o_ctrl.link_value = i_req.pc + xlen_t'(4);
                    o_ctrl.taken      = 1'b1;
                    o_ctrl.target     = {jalr_sum[xlen-1:1], 1'b0};
                end
            end
            op_branch: begin
                o_ctrl.taken  = cond;
                o_ctrl.target = i_req.pc + imm_b;
            end
            op_load: begin
                o_ctrl.mem.rd   = inst.i.rd;
                o_ctrl.mem.addr = rs1 + imm_i;
                o_ctrl.mem.size = size;
                case (inst.i.funct3)
                    f3_mem_b, f3_mem_h, f3_mem_w: begin
                        o_ctrl.mem.load     = 1'b1;
                        o_ctrl.mem.sign_ext = 1'b1;
                    end
                    f3_mem_d, f3_mem_bu, f3_mem_hu, f3_mem_wu: o_ctrl.mem.load = 1'b1;
                    default: o_ctrl.mem.load = 1'b0;
                endcase
            end
            op_store: begin
                o_ctrl.mem.addr  = rs1 + imm_s;
                o_ctrl.mem.size  = size;
                o_ctrl.mem.wdata = rs2 & size_mask;
                case (inst.s.funct3)
                    f3_mem_b, f3_mem_h, f3_mem_w, f3_mem_d: o_ctrl.mem.store = 1'b1;
                    default: o_ctrl.mem.store = 1'b0;
                endcase
            end
            op_system: o_ctrl.ecall = inst.i.funct3 == 3'b000 && inst.i.imm == '0;
            default: o_ctrl = '0;
        endcase
    end

    // sampled on each new request, covers the settled previous one
    a_mem_onehot: assert property (@(i_req)
        !(o_ctrl.mem.load === 1'b1 && o_ctrl.mem.store === 1'b1))
        else $error("load and store requested together");

    a_jalr_align: assert property (@(i_req)
        (inst.i.opcode == op_jalr && o_ctrl.taken) |-> o_ctrl.target[0] == 1'b0)
        else $error("jalr target with bit 0 set");

endmodule

`default_nettype wire

//--- src/int_alu.sv
// integer ALU for op, op-imm, their W forms, lui and auipc
`default_nettype none

module int_alu
    import rv_isa_pkg::*;
    import exec_pkg::*;
(
    input  exec_req_t   i_req,
    output alu_result_t o_alu
);

    inst_t      inst;
    xlen_t      imm_i;
    xlen_t      imm_u;
    xlen_t      src_a;
    xlen_t      src_b;
    xlen_t      shift_in;
    xlen_t      op_res;
    word_t      op_word;
    logic [5:0] shamt;
    logic       is_imm;
    logic       is_word;
    logic       alt;
    logic       f7_zero;
    logic       f7_alt;
    logic       f6_zero;
    logic       f6_alt;
    logic       op_ok;

    function automatic xlen_t sext_word(word_t w);
        return {{(xlen-word_width){w[word_width-1]}}, w};
    endfunction

    always_comb begin
        inst    = i_req.inst;
        is_imm  = inst.r.opcode inside {op_imm, op_imm32};
        is_word = inst.r.opcode inside {op_imm32, op_reg32};
        alt     = inst.r.funct7[5];                     // instruction bit 30
        f7_zero = inst.r.funct7 == '0;
        f7_alt  = inst.r.funct7 == funct7_alt;
        f6_zero = inst.r.funct7[6:1] == '0;             // bit 25 is shamt[5] on rv64
        f6_alt  = inst.r.funct7[6:1] == funct7_alt[6:1];

        imm_i = {{(xlen-12){inst.i.imm[11]}}, inst.i.imm};
        imm_u = sext_word({inst.u.imm, 12'h000});
        src_a = i_req.rs1_val;
        src_b = is_imm ? imm_i : i_req.rs2_val;
        shamt = is_word ? {1'b0, src_b[4:0]} : src_b[5:0];

        // srlw/sraw shift a pre-extended low word
        if (is_word) begin
            shift_in = alt ? sext_word(src_a[word_width-1:0]) : xlen_t'(src_a[word_width-1:0]);
        end else begin
            shift_in = src_a;
        end
    end

    always_comb begin
        case (inst.r.funct3)
            f3_add_sub: op_res = (!is_imm && alt) ? src_a - src_b : src_a + src_b;
            f3_sll:     op_res = src_a << shamt;
            f3_slt:     op_res = xlen_t'($signed(src_a) < $signed(src_b));
            f3_sltu:    op_res = xlen_t'(src_a < src_b);
            f3_xor:     op_res = src_a ^ src_b;
            f3_srl_sra: begin
                if (alt) begin
                    op_res = $signed(shift_in) >>> shamt;
                end else begin
                    op_res = shift_in >> shamt;
                end
            end
            f3_or:      op_res = src_a | src_b;
            f3_and:     op_res = src_a & src_b;
            default:    op_res = '0;
        endcase
        op_word = op_res[word_width-1:0];
    end

    // funct7 legality per opcode
    always_comb begin
        case (inst.r.opcode)
            op_imm: begin
                case (inst.r.funct3)
                    f3_sll:     op_ok = f6_zero;
                    f3_srl_sra: op_ok = f6_zero || f6_alt;
                    default:    op_ok = 1'b1;
                endcase
            end
            op_imm32: begin
                case (inst.r.funct3)
                    f3_add_sub: op_ok = 1'b1;    // addiw
                    f3_sll:     op_ok = f7_zero;
                    f3_srl_sra: op_ok = f7_zero || f7_alt;
                    default:    op_ok = 1'b0;
                endcase
            end
            op_reg: begin
                case (inst.r.funct3)
                    f3_add_sub, f3_srl_sra: op_ok = f7_zero || f7_alt;
                    default:                op_ok = f7_zero;
                endcase
            end
            op_reg32: begin
                case (inst.r.funct3)
                    f3_add_sub, f3_srl_sra: op_ok = f7_zero || f7_alt;
                    f3_sll:                 op_ok = f7_zero;
                    default:                op_ok = 1'b0;
                endcase
            end
            default: op_ok = 1'b0;
        endcase
    end

    always_comb begin
        o_alu = '0;
        case (inst.r.opcode)
            op_lui: begin
                o_alu.hit   = 1'b1;
                o_alu.value = imm_u;
            end
            op_auipc: begin
                o_alu.hit   = 1'b1;
                o_alu.value = i_req.pc + imm_u;
            end
            op_imm, op_reg: begin
                o_alu.hit   = op_ok;
                o_alu.value = op_res;
            end
            op_imm32, op_reg32: begin
                o_alu.hit   = op_ok;
                o_alu.value = sext_word(op_word);
            end
            default: o_alu = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- src/exec_pkg.sv
// execute stage request, unit result, memory request, writeback and redirect structs
`default_nettype none

package exec_pkg;

    import rv_isa_pkg::*;

    typedef enum logic [1:0] {
        size_byte   = 2'd0,
        size_half   = 2'd1,
        size_word   = 2'd2,
        size_double = 2'd3
    } mem_size_e;

    // one decoded instruction entering the stage
    typedef struct packed {
        xlen_t pc;
        inst_t inst;
        xlen_t rs1_val;
        xlen_t rs2_val;
    } exec_req_t;

    typedef struct packed {
        logic  hit;     // instruction belongs to the ALU
        xlen_t value;
    } alu_result_t;

    typedef struct packed {
        logic      load;
        logic      store;
        reg_addr_t rd;       // load destination
        xlen_t     addr;
        xlen_t     wdata;    // already masked to size
        mem_size_e size;
        logic      sign_ext;
    } mem_req_t;

    typedef struct packed {
        logic     link;
        xlen_t    link_value;
        logic     taken;
        xlen_t    target;
        mem_req_t mem;
        logic     ecall;
    } ctrl_result_t;

    typedef struct packed {
        logic      en;
        reg_addr_t rd;
        xlen_t     value;
    } wb_t;

    typedef struct packed {
        logic  taken;
        xlen_t target;
    } redirect_t;

endpackage

`default_nettype wire

//--- src/rv_isa_pkg.sv
// RV64I opcode and funct encodings, instruction format union, register width constants
`default_nettype none

package rv_isa_pkg;

    localparam int xlen           = 64;
    localparam int word_width     = 32;    // W-form operand width
    localparam int reg_addr_width = 5;

    typedef logic [xlen-1:0]           xlen_t;
    typedef logic [word_width-1:0]     word_t;
    typedef logic [reg_addr_width-1:0] reg_addr_t;

    // major opcodes
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_imm32  = 7'b0011011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_reg32  = 7'b0111011;
    localparam logic [6:0] op_system = 7'b1110011;

    // integer ops
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    // branches
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    // load/store sizes, bit 2 set on zero-extending loads
    localparam logic [2:0] f3_mem_b  = 3'b000;
    localparam logic [2:0] f3_mem_h  = 3'b001;
    localparam logic [2:0] f3_mem_w  = 3'b010;
    localparam logic [2:0] f3_mem_d  = 3'b011;
    localparam logic [2:0] f3_mem_bu = 3'b100;
    localparam logic [2:0] f3_mem_hu = 3'b101;
    localparam logic [2:0] f3_mem_wu = 3'b110;

    localparam logic [6:0] funct7_alt = 7'b0100000;    // sub, sra

    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;     // bits 31:12 of the value
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one instruction word, six views
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } inst_t;

endpackage

`default_nettype wire
